//--- common/flight_pkg.sv
// flight_pkg: data widths, stick/attitude/gyro/rate/motor structs, sequencer states, clamp helper
`default_nettype none

package flight_pkg;

	// receiver sticks are unsigned bytes, everything downstream is signed 12.4
	localparam int REC_WIDTH  = 8;
	localparam int RATE_WIDTH = 16;

	// gain values are 12.4, so products drop four fraction bits
	localparam int GAIN_SHIFT = 4;

	// motor upper clamp, shared with the testbench model
	localparam int MOTOR_MAX = 4000;

	typedef struct packed {
		logic [REC_WIDTH-1:0] throttle;
		logic [REC_WIDTH-1:0] yaw;
		logic [REC_WIDTH-1:0] pitch;
		logic [REC_WIDTH-1:0] roll;
	} rc_target_t;

	typedef struct packed {
		logic signed [RATE_WIDTH-1:0] pitch;
		logic signed [RATE_WIDTH-1:0] roll;
	} attitude_t;

	typedef struct packed {
		logic signed [RATE_WIDTH-1:0] yaw;
		logic signed [RATE_WIDTH-1:0] pitch;
		logic signed [RATE_WIDTH-1:0] roll;
	} gyro_t;

	typedef struct packed {
		logic signed [RATE_WIDTH-1:0] throttle;
		logic signed [RATE_WIDTH-1:0] yaw;
		logic signed [RATE_WIDTH-1:0] pitch;
		logic signed [RATE_WIDTH-1:0] roll;
	} rate_cmd_t;

	typedef struct packed {
		logic signed [RATE_WIDTH-1:0] pitch;
		logic signed [RATE_WIDTH-1:0] roll;
	} angle_err_t;

	typedef struct packed {
		logic signed [RATE_WIDTH-1:0] m0;
		logic signed [RATE_WIDTH-1:0] m1;
		logic signed [RATE_WIDTH-1:0] m2;
		logic signed [RATE_WIDTH-1:0] m3;
	} motor_t;

	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_ANGLE,
		SEQ_RATE,
		SEQ_MIX,
		SEQ_DONE
	} seq_state_t;

	// saturate a wide signed value into a rate word
	function automatic logic signed [RATE_WIDTH-1:0] clamp_rate(
		input logic signed [31:0] value,
		input int lo,
		input int hi
	);
		if (value > hi)
			return RATE_WIDTH'(hi);
		else if (value < lo)
			return RATE_WIDTH'(lo);
		return value[RATE_WIDTH-1:0];
	endfunction

endpackage

`default_nettype wire

//--- hdl/loop_timer.sv
// loop_timer: periodic one-cycle update tick, cleared while disabled
`timescale 1ns/1ps
`default_nettype none

module loop_timer #(
	parameter int UPDATE_PERIOD = 1000
) (
	input  wire logic us_clk,
	input  wire logic resetn,
	input  wire logic enable,
	output logic      tick
);

	localparam int CNT_W = (UPDATE_PERIOD > 1) ? $clog2(UPDATE_PERIOD) : 1;

	logic [CNT_W-1:0] count;

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			count <= '0;
			tick  <= 1'b0;
		end else if (!enable) begin
			// hold at zero so the first tick comes a full period after enable
			count <= '0;
			tick  <= 1'b0;
		end else if (count == CNT_W'(UPDATE_PERIOD - 1)) begin
			count <= '0;
			tick  <= 1'b1;
		end else begin
			count <= count + 1'b1;
			tick  <= 1'b0;
		end
	end

	a_no_tick_disabled: assert property (@(posedge us_clk) disable iff (!resetn)
		!enable |=> !tick);

endmodule

`default_nettype wire

//--- hdl/flight_sequencer.sv
// flight_sequencer: FSM that runs angle, rate and mix stages per tick and flags loop completion
`timescale 1ns/1ps
`default_nettype none

module flight_sequencer (
	input  wire logic us_clk,
	input  wire logic resetn,
	input  wire logic tick,
	input  wire logic angle_done,
	input  wire logic rate_done,
	input  wire logic mix_done,
	output logic      angle_start,
	output logic      rate_start,
	output logic      mix_start,
	output logic      busy,
	output logic      loop_done
);

	import flight_pkg::*;

	seq_state_t state;

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state       <= SEQ_IDLE;
			angle_start <= 1'b0;
			rate_start  <= 1'b0;
			mix_start   <= 1'b0;
			loop_done   <= 1'b0;
		end else begin
			// strobes are single-cycle unless set below
			angle_start <= 1'b0;
			rate_start  <= 1'b0;
			mix_start   <= 1'b0;
			loop_done   <= 1'b0;
			case (state)
				SEQ_IDLE: begin
					if (tick) begin
						state       <= SEQ_ANGLE;
						angle_start <= 1'b1;
					end
				end
				SEQ_ANGLE: begin
					if (angle_done) begin
						state      <= SEQ_RATE;
						rate_start <= 1'b1;
					end
				end
				SEQ_RATE: begin
					if (rate_done) begin
						state     <= SEQ_MIX;
						mix_start <= 1'b1;
					end
				end
				SEQ_MIX: begin
					if (mix_done) begin
						state     <= SEQ_DONE;
						loop_done <= 1'b1;
					end
				end
				// ticks seen here or in any busy state are dropped
				SEQ_DONE: begin
					state <= SEQ_IDLE;
				end
				default: begin
					state <= SEQ_IDLE;
				end
			endcase
		end
	end

	assign busy = (state != SEQ_IDLE);

	a_one_start: assert property (@(posedge us_clk) disable iff (!resetn)
		$onehot0({angle_start, rate_start, mix_start}));

endmodule

`default_nettype wire

//--- angle_control/angle_controller.sv
// angle_controller: stick and attitude mapping, gain scaling and limiting into rate targets
`timescale 1ns/1ps
`default_nettype none

module angle_controller #(
	parameter int YAW_GAIN       = 48,
	parameter int PITCH_GAIN     = 32,
	parameter int ROLL_GAIN      = 32,
	parameter int THROTTLE_MAX   = 4000,
	parameter int ANGLE_RATE_MAX = 1600
) (
	input  wire logic                   us_clk,
	input  wire logic                   resetn,
	input  wire logic                   start,
	input  wire flight_pkg::rc_target_t targets,
	input  wire flight_pkg::attitude_t  attitude,
	output logic                        active,
	output logic                        complete,
	output flight_pkg::rate_cmd_t       rate_cmd,
	output flight_pkg::angle_err_t      angle_error
);

	import flight_pkg::*;

	typedef enum logic [1:0] {
		ANG_IDLE,
		ANG_MAP,
		ANG_SCALE,
		ANG_LIMIT
	} ang_state_t;

	// centre stick 125 times 4
	localparam logic signed [RATE_WIDTH-1:0] STICK_OFFSET = 500;

	ang_state_t state;

	rc_target_t sticks;
	attitude_t  angles;

	logic signed [RATE_WIDTH-1:0] map_throttle;
	logic signed [RATE_WIDTH-1:0] map_yaw;
	logic signed [RATE_WIDTH-1:0] map_pitch;
	logic signed [RATE_WIDTH-1:0] map_roll;

	logic signed [31:0] scl_throttle;
	logic signed [31:0] scl_yaw;
	logic signed [31:0] scl_pitch;
	logic signed [31:0] scl_roll;

	// 0..250 byte to -31.25..+31.25 in 12.4
	function automatic logic signed [RATE_WIDTH-1:0] centre_stick(
		input logic [REC_WIDTH-1:0] stick
	);
		return $signed({{(RATE_WIDTH-REC_WIDTH-2){1'b0}}, stick, 2'b00}) - STICK_OFFSET;
	endfunction

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state       <= ANG_IDLE;
			complete    <= 1'b0;
			rate_cmd    <= '0;
			angle_error <= '0;
		end else begin
			complete <= 1'b0;
			case (state)
				ANG_IDLE: begin
					if (start)
						state <= ANG_MAP;
				end
				ANG_MAP: begin
					state <= ANG_SCALE;
				end
				ANG_SCALE: begin
					state <= ANG_LIMIT;
				end
				ANG_LIMIT: begin
					state             <= ANG_IDLE;
					complete          <= 1'b1;
					rate_cmd.throttle <= clamp_rate(scl_throttle, 0, THROTTLE_MAX);
					rate_cmd.yaw      <= clamp_rate(scl_yaw, -ANGLE_RATE_MAX, ANGLE_RATE_MAX);
					rate_cmd.pitch    <= clamp_rate(scl_pitch, -ANGLE_RATE_MAX, ANGLE_RATE_MAX);
					rate_cmd.roll     <= clamp_rate(scl_roll, -ANGLE_RATE_MAX, ANGLE_RATE_MAX);
					angle_error.pitch <= map_pitch;
					angle_error.roll  <= map_roll;
				end
				default: begin
					state <= ANG_IDLE;
				end
			endcase
		end
	end

	// datapath registers, advanced by the FSM state
	always_ff @(posedge us_clk) begin
		if (state == ANG_IDLE && start) begin
			sticks <= targets;
			angles <= attitude;
		end
		if (state == ANG_MAP) begin
			map_throttle <= $signed({{(RATE_WIDTH-REC_WIDTH-4){1'b0}}, sticks.throttle, 4'b0000});
			map_yaw      <= centre_stick(sticks.yaw);
			map_pitch    <= centre_stick(sticks.pitch) - angles.pitch;
			// imu roll axis is mirrored
			map_roll     <= centre_stick(sticks.roll) + angles.roll;
		end
		if (state == ANG_SCALE) begin
			// throttle has unity gain
			scl_throttle <= map_throttle;
			scl_yaw      <= (map_yaw * YAW_GAIN) >>> GAIN_SHIFT;
			scl_pitch    <= (map_pitch * PITCH_GAIN) >>> GAIN_SHIFT;
			scl_roll     <= (map_roll * ROLL_GAIN) >>> GAIN_SHIFT;
		end
	end

	assign active = (state != ANG_IDLE);

endmodule

`default_nettype wire

//--- rate_control/rate_controller.sv
// rate_controller: proportional correction of rate targets against gyro rates with limiting
`timescale 1ns/1ps
`default_nettype none

module rate_controller #(
	parameter int RATE_KP  = 16,
	parameter int RATE_MAX = 1600
) (
	input  wire logic                  us_clk,
	input  wire logic                  resetn,
	input  wire logic                  start,
	input  wire flight_pkg::rate_cmd_t rate_target,
	input  wire flight_pkg::gyro_t     gyro,
	output logic                       complete,
	output flight_pkg::rate_cmd_t      rate_out
);

	import flight_pkg::*;

	typedef enum logic [1:0] {
		RC_IDLE,
		RC_ERROR,
		RC_LIMIT
	} rc_state_t;

	rc_state_t state;

	rate_cmd_t target_q;
	gyro_t     gyro_q;

	// one extra bit so target minus gyro cannot wrap
	logic signed [RATE_WIDTH:0] err_yaw;
	logic signed [RATE_WIDTH:0] err_pitch;
	logic signed [RATE_WIDTH:0] err_roll;

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state    <= RC_IDLE;
			complete <= 1'b0;
			rate_out <= '0;
		end else begin
			complete <= 1'b0;
			case (state)
				RC_IDLE: begin
					if (start)
						state <= RC_ERROR;
				end
				RC_ERROR: begin
					state <= RC_LIMIT;
				end
				RC_LIMIT: begin
					state             <= RC_IDLE;
					complete          <= 1'b1;
					rate_out.throttle <= target_q.throttle;
					rate_out.yaw      <= clamp_rate((err_yaw * RATE_KP) >>> GAIN_SHIFT,
						-RATE_MAX, RATE_MAX);
					rate_out.pitch    <= clamp_rate((err_pitch * RATE_KP) >>> GAIN_SHIFT,
						-RATE_MAX, RATE_MAX);
					rate_out.roll     <= clamp_rate((err_roll * RATE_KP) >>> GAIN_SHIFT,
						-RATE_MAX, RATE_MAX);
				end
				default: begin
					state <= RC_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge us_clk) begin
		if (state == RC_IDLE && start) begin
			target_q <= rate_target;
			gyro_q   <= gyro;
		end
		if (state == RC_ERROR) begin
			err_yaw   <= target_q.yaw - gyro_q.yaw;
			err_pitch <= target_q.pitch - gyro_q.pitch;
			err_roll  <= target_q.roll - gyro_q.roll;
		end
	end

endmodule

`default_nettype wire

//--- hdl/motor_mixer.sv
// motor_mixer: X-frame mix of throttle, yaw, pitch and roll into four clamped motor commands
`timescale 1ns/1ps
`default_nettype none

module motor_mixer (
	input  wire logic                  us_clk,
	input  wire logic                  resetn,
	input  wire logic                  start,
	input  wire flight_pkg::rate_cmd_t cmd,
	output logic                       complete,
	output flight_pkg::motor_t         motors
);

	import flight_pkg::*;

	typedef enum logic [1:0] {
		MIX_IDLE,
		MIX_SUM,
		MIX_CLAMP
	} mix_state_t;

	// headroom for throttle plus three full-scale axes
	localparam int SUM_W = RATE_WIDTH + 2;

	mix_state_t state;
	rate_cmd_t  cmd_q;

	logic signed [SUM_W-1:0] thr;
	logic signed [SUM_W-1:0] yaw;
	logic signed [SUM_W-1:0] pitch;
	logic signed [SUM_W-1:0] roll;
	logic signed [SUM_W-1:0] sum0;
	logic signed [SUM_W-1:0] sum1;
	logic signed [SUM_W-1:0] sum2;
	logic signed [SUM_W-1:0] sum3;

	assign thr   = cmd_q.throttle;
	assign yaw   = cmd_q.yaw;
	assign pitch = cmd_q.pitch;
	assign roll  = cmd_q.roll;

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state    <= MIX_IDLE;
			complete <= 1'b0;
			motors   <= '0;
		end else begin
			complete <= 1'b0;
			case (state)
				MIX_IDLE: begin
					if (start)
						state <= MIX_SUM;
				end
				MIX_SUM: begin
					state <= MIX_CLAMP;
				end
				MIX_CLAMP: begin
					state     <= MIX_IDLE;
					complete  <= 1'b1;
					motors.m0 <= clamp_rate(sum0, 0, MOTOR_MAX);
					motors.m1 <= clamp_rate(sum1, 0, MOTOR_MAX);
					motors.m2 <= clamp_rate(sum2, 0, MOTOR_MAX);
					motors.m3 <= clamp_rate(sum3, 0, MOTOR_MAX);
				end
				default: begin
					state <= MIX_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge us_clk) begin
		if (state == MIX_IDLE && start)
			cmd_q <= cmd;
		if (state == MIX_SUM) begin
			// front pair gains on pitch, diagonal pairs share yaw direction
			sum0 <= thr + pitch + roll - yaw;
			sum1 <= thr + pitch - roll + yaw;
			sum2 <= thr - pitch - roll - yaw;
			sum3 <= thr - pitch + roll + yaw;
		end
	end

	a_motor_range: assert property (@(posedge us_clk) disable iff (!resetn)
		complete |-> (motors.m0 >= 0 && motors.m0 <= MOTOR_MAX &&
			motors.m1 >= 0 && motors.m1 <= MOTOR_MAX &&
			motors.m2 >= 0 && motors.m2 <= MOTOR_MAX &&
			motors.m3 >= 0 && motors.m3 <= MOTOR_MAX));

endmodule

`default_nettype wire

//--- hdl/flight_core.sv
// flight_core: loop timer, sequencer, angle and rate controllers and motor mixer
`timescale 1ns/1ps
`default_nettype none

module flight_core #(
	parameter int UPDATE_PERIOD  = 1000,
	parameter int YAW_GAIN       = 48,
	parameter int PITCH_GAIN     = 32,
	parameter int ROLL_GAIN      = 32,
	parameter int THROTTLE_MAX   = 4000,
	parameter int ANGLE_RATE_MAX = 1600,
	parameter int RATE_KP        = 16,
	parameter int RATE_MAX       = 1600
) (
	input  wire logic                   us_clk,
	input  wire logic                   resetn,
	input  wire logic                   enable,
	input  wire flight_pkg::rc_target_t targets,
	input  wire flight_pkg::attitude_t  attitude,
	input  wire flight_pkg::gyro_t      gyro,
	output flight_pkg::motor_t          motors,
	output flight_pkg::angle_err_t      angle_error,
	output logic                        busy,
	output logic                        loop_done
);

	import flight_pkg::*;

	logic tick;
	logic angle_start;
	logic rate_start;
	logic mix_start;
	logic angle_done;
	logic rate_done;
	logic mix_done;

	rate_cmd_t angle_cmd;
	rate_cmd_t rate_cmd;

	loop_timer #(
		.UPDATE_PERIOD(UPDATE_PERIOD)
	) u_timer (
		.us_clk(us_clk),
		.resetn(resetn),
		.enable(enable),
		.tick  (tick)
	);

	flight_sequencer u_seq (
		.us_clk     (us_clk),
		.resetn     (resetn),
		.tick       (tick),
		.angle_done (angle_done),
		.rate_done  (rate_done),
		.mix_done   (mix_done),
		.angle_start(angle_start),
		.rate_start (rate_start),
		.mix_start  (mix_start),
		.busy       (busy),
		.loop_done  (loop_done)
	);

	// active level is only for observation, the sequencer runs on done pulses
	angle_controller #(
		.YAW_GAIN      (YAW_GAIN),
		.PITCH_GAIN    (PITCH_GAIN),
		.ROLL_GAIN     (ROLL_GAIN),
		.THROTTLE_MAX  (THROTTLE_MAX),
		.ANGLE_RATE_MAX(ANGLE_RATE_MAX)
	) u_angle (
		.us_clk     (us_clk),
		.resetn     (resetn),
		.start      (angle_start),
		.targets    (targets),
		.attitude   (attitude),
		.active     (),
		.complete   (angle_done),
		.rate_cmd   (angle_cmd),
		.angle_error(angle_error)
	);

	rate_controller #(
		.RATE_KP (RATE_KP),
		.RATE_MAX(RATE_MAX)
	) u_rate (
		.us_clk     (us_clk),
		.resetn     (resetn),
		.start      (rate_start),
		.rate_target(angle_cmd),
		.gyro       (gyro),
		.complete   (rate_done),
		.rate_out   (rate_cmd)
	);

	motor_mixer u_mixer (
		.us_clk  (us_clk),
		.resetn  (resetn),
		.start   (mix_start),
		.cmd     (rate_cmd),
		.complete(mix_done),
		.motors  (motors)
	);

endmodule

`default_nettype wire

//--- test/tb_clock.sv
// tb_clock: free-running testbench clock and power-on reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS    = 8,
	parameter int RESET_CYCLES = 16
) (
	output logic us_clk,
	output logic resetn
);

	initial begin
		us_clk = 1'b0;
		forever #(PERIOD_NS / 2) us_clk = ~us_clk;
	end

	// release on a rising edge so the first active cycle is a full one
	initial begin
		resetn = 1'b0;
		repeat (RESET_CYCLES) @(posedge us_clk);
		resetn <= 1'b1;
	end

endmodule

`default_nettype wire

//--- test/flight_core_tb.sv
// flight_core_tb: table-driven testbench for flight_core, loop rate, enable hold and watchdog
`timescale 1ns/1ps
`default_nettype none

module flight_core_tb;

	import flight_pkg::*;

	localparam int UPDATE_PERIOD = 32;
	localparam int NUM_VECS      = 10;
	// table loops, then the enable-low hold and the resume, plus slack for reset
	localparam int WATCHDOG_CYCLES = NUM_VECS * UPDATE_PERIOD * 4 + 8 * UPDATE_PERIOD + 200;

	typedef struct packed {
		rc_target_t targets;
		attitude_t  attitude;
		gyro_t      gyro;
		motor_t     motors;
		angle_err_t angle_error;
	} test_vec_t;

	logic       us_clk;
	logic       resetn;
	logic       enable;
	rc_target_t targets;
	attitude_t  attitude;
	gyro_t      gyro;
	motor_t     motors;
	angle_err_t angle_error;
	logic       busy;
	logic       loop_done;

	test_vec_t vecs[$];
	string     names[$];

	int error_count   = 0;
	int timeout_count = 0;
	int cycle_count   = 0;

	tb_clock #(
		.PERIOD_NS   (8),
		.RESET_CYCLES(16)
	) u_clock (
		.us_clk(us_clk),
		.resetn(resetn)
	);

	flight_core #(
		.UPDATE_PERIOD(UPDATE_PERIOD)
	) dut (
		.us_clk     (us_clk),
		.resetn     (resetn),
		.enable     (enable),
		.targets    (targets),
		.attitude   (attitude),
		.gyro       (gyro),
		.motors     (motors),
		.angle_error(angle_error),
		.busy       (busy),
		.loop_done  (loop_done)
	);

	always @(posedge us_clk)
		cycle_count <= cycle_count + 1;

	task automatic add_vec(
		input string      name,
		input rc_target_t t,
		input attitude_t  a,
		input gyro_t      g,
		input motor_t     m,
		input angle_err_t e
	);
		vecs.push_back({t, a, g, m, e});
		names.push_back(name);
	endtask

	// columns: sticks thr/yaw/pitch/roll, attitude pitch/roll, gyro yaw/pitch/roll,
	// motors m0..m3, angle error pitch/roll
	task automatic load_vectors();
		add_vec("centred_hover", {8'd125, 8'd125, 8'd125, 8'd125}, {16'sd0, 16'sd0},
			{16'sd0, 16'sd0, 16'sd0}, {16'sd2000, 16'sd2000, 16'sd2000, 16'sd2000},
			{16'sd0, 16'sd0});
		add_vec("full_throttle", {8'd250, 8'd125, 8'd125, 8'd125}, {16'sd0, 16'sd0},
			{16'sd0, 16'sd0, 16'sd0}, {16'sd4000, 16'sd4000, 16'sd4000, 16'sd4000},
			{16'sd0, 16'sd0});
		add_vec("pitch_angle", {8'd125, 8'd125, 8'd125, 8'd125}, {16'sd160, 16'sd0},
			{16'sd0, 16'sd0, 16'sd0}, {16'sd1680, 16'sd1680, 16'sd2320, 16'sd2320},
			{-16'sd160, 16'sd0});
		// mirrored imu roll adds to the stick
		add_vec("roll_angle", {8'd125, 8'd125, 8'd125, 8'd125}, {16'sd0, 16'sd160},
			{16'sd0, 16'sd0, 16'sd0}, {16'sd2320, 16'sd1680, 16'sd1680, 16'sd2320},
			{16'sd0, 16'sd160});
		add_vec("gyro_pitch", {8'd125, 8'd125, 8'd125, 8'd125}, {16'sd0, 16'sd0},
			{16'sd0, 16'sd100, 16'sd0}, {16'sd1900, 16'sd1900, 16'sd2100, 16'sd2100},
			{16'sd0, 16'sd0});
		add_vec("gyro_roll_yaw", {8'd125, 8'd125, 8'd125, 8'd125}, {16'sd0, 16'sd0},
			{-16'sd50, 16'sd0, 16'sd80}, {16'sd1870, 16'sd2130, 16'sd2030, 16'sd1970},
			{16'sd0, 16'sd0});
		// full yaw stick is 1500, the gyro pushes the rate error past the limit
		add_vec("yaw_saturate", {8'd25, 8'd250, 8'd125, 8'd125}, {16'sd0, 16'sd0},
			{-16'sd300, 16'sd0, 16'sd0}, {16'sd0, 16'sd2000, 16'sd0, 16'sd2000},
			{16'sd0, 16'sd0});
		add_vec("pitch_saturate", {8'd100, 8'd125, 8'd250, 8'd125}, {-16'sd400, 16'sd0},
			{16'sd0, 16'sd0, 16'sd0}, {16'sd3200, 16'sd3200, 16'sd0, 16'sd0},
			{16'sd900, 16'sd0});
		add_vec("roll_low_stick", {8'd200, 8'd125, 8'd125, 8'd0}, {16'sd0, 16'sd0},
			{16'sd0, 16'sd0, 16'sd0}, {16'sd2200, 16'sd4000, 16'sd4000, 16'sd2200},
			{16'sd0, -16'sd500});
		add_vec("zero_throttle_yaw", {8'd0, 8'd150, 8'd125, 8'd125}, {16'sd0, 16'sd0},
			{16'sd0, 16'sd0, 16'sd0}, {16'sd0, 16'sd300, 16'sd0, 16'sd300},
			{16'sd0, 16'sd0});
	endtask

	task automatic check_value(
		input string name,
		input string what,
		input int    expected,
		input int    actual
	);
		assert (actual == expected)
		else begin
			$display("Fail %s %s: expected %0d, actual %0d", name, what, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_outputs(input string name, input test_vec_t v);
		check_value(name, "m0", v.motors.m0, motors.m0);
		check_value(name, "m1", v.motors.m1, motors.m1);
		check_value(name, "m2", v.motors.m2, motors.m2);
		check_value(name, "m3", v.motors.m3, motors.m3);
		check_value(name, "angle_error.pitch", v.angle_error.pitch, angle_error.pitch);
		check_value(name, "angle_error.roll", v.angle_error.roll, angle_error.roll);
	endtask

	// samples on the falling edge, returns as soon as loop_done is seen
	task automatic wait_loop_done(input int max_cycles, output bit seen);
		int waited;
		seen   = 1'b0;
		waited = 0;
		while (!seen && waited < max_cycles) begin
			@(negedge us_clk);
			waited++;
			if (loop_done)
				seen = 1'b1;
		end
	endtask

	task automatic print_counts();
		$display("errors: %0d check failures, %0d timeouts", error_count, timeout_count);
	endtask

	initial begin
		bit        seen;
		int        last_done_cycle;
		test_vec_t held;
		enable          = 1'b0;
		targets         = '0;
		attitude        = '0;
		gyro            = '0;
		last_done_cycle = 0;
		load_vectors();

		@(posedge resetn);
		@(negedge us_clk);
		check_value("after_reset", "busy", 0, busy);
		check_value("after_reset", "loop_done", 0, loop_done);
		check_outputs("after_reset", '0);

		@(posedge us_clk);
		enable <= 1'b1;

		// new inputs go in right after loop_done, well before the next tick
		for (int i = 0; i < vecs.size(); i++) begin
			@(posedge us_clk);
			targets  <= vecs[i].targets;
			attitude <= vecs[i].attitude;
			gyro     <= vecs[i].gyro;
			wait_loop_done(2 * UPDATE_PERIOD, seen);
			if (!seen) begin
				$display("timeout: no loop_done seen for entry %s", names[i]);
				timeout_count++;
			end else begin
				check_outputs(names[i], vecs[i]);
				check_value(names[i], "busy at loop_done", 1, busy);
				if (i > 0)
					check_value(names[i], "loop period", UPDATE_PERIOD,
						cycle_count - last_done_cycle);
				last_done_cycle = cycle_count;
			end
		end

		// disabled, new inputs must not reach the motors
		held = vecs[vecs.size() - 1];
		@(posedge us_clk);
		enable   <= 1'b0;
		targets  <= vecs[0].targets;
		attitude <= vecs[0].attitude;
		gyro     <= vecs[0].gyro;
		for (int c = 0; c < 4 * UPDATE_PERIOD; c++) begin
			@(negedge us_clk);
			assert (!loop_done)
			else begin
				$display("loop_done pulsed while enable was low, %0d cycles in", c);
				error_count++;
			end
		end
		check_outputs("enable_low_hold", held);

		@(posedge us_clk);
		enable <= 1'b1;
		wait_loop_done(2 * UPDATE_PERIOD, seen);
		if (!seen) begin
			$display("timeout: loop_done did not resume after enable returned");
			timeout_count++;
		end else begin
			check_outputs("enable_resume", vecs[0]);
		end

		print_counts();
		if (error_count == 0 && timeout_count == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge us_clk);
		$display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		timeout_count++;
		print_counts();
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
common/flight_pkg.sv
hdl/loop_timer.sv
hdl/flight_sequencer.sv
angle_control/angle_controller.sv
rate_control/rate_controller.sv
hdl/motor_mixer.sv
hdl/flight_core.sv
test/tb_clock.sv
test/flight_core_tb.sv

//--- Makefile
# Verilator build and run for the flight_core testbench

TOP := flight_core_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f all.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^Simulation completed successfully$$" $(LOG) || \
		{ echo "run failed, see $(LOG)"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
